// ==== build.f ====
+incdir+verilog
verilog/sd_host_pkg.sv
verilog/zpu_io_pkg.sv
verilog/sector_port_if.sv
verilog/sector_buffer.sv
verilog/disk_request_ctrl.sv
verilog/mount_tracker.sv
verilog/disk_bridge_top.sv
dv/disk_bridge_checker.sv
dv/disk_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: disk_bridge

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sd_host_pkg.sv
      - verilog/zpu_io_pkg.sv
      - verilog/sector_port_if.sv
      - verilog/sector_buffer.sv
      - verilog/disk_request_ctrl.sv
      - verilog/mount_tracker.sv
      - verilog/disk_bridge_top.sv
  - target: simulation
    files:
      - dv/disk_bridge_checker.sv
      - dv/disk_bridge_tb.sv

// ==== dv/disk_bridge_patterns.txt ====
# Columns: test op a b c expected, all numbers in hex
# cwr a=lba_sel b=data, hwr/hrd a=addr b=data, blkrd/blkwr a=drive b=ack hold, mount a=slots b={ro,type} c=size, status a=mask
roundtrip iowr  0   0        0        0
roundtrip cwr   0   5a       0        0
roundtrip cwr   0   a5       0        0
roundtrip cwr   0   3c       0        0
roundtrip cwr   0   c3       0        0
roundtrip iowr  0   0        0        0
roundtrip crd   0   0        0        5a
roundtrip crd   0   0        0        a5
roundtrip crd   0   0        0        3c
roundtrip crd   0   0        0        c3
host_xfer hwr   0   11       0        0
host_xfer hwr   1   22       0        0
host_xfer hwr   2   33       0        0
host_xfer hwr   1ff 44       0        0
host_xfer iowr  0   0        0        0
host_xfer crd   0   0        0        11
host_xfer crd   0   0        0        22
host_xfer crd   0   0        0        33
host_xfer iowr  0   0        0        0
host_xfer cwr   0   e1       0        0
host_xfer cwr   0   e2       0        0
host_xfer hrd   0   0        0        e1
host_xfer hrd   1   0        0        e2
host_xfer hrd   2   0        0        33
host_xfer hrd   1ff 0        0        44
blk_read  cwr   1   12345678 0        12345678
blk_read  blkrd 0   0        0        01
blk_read  blkrd 1   0        0        02
blk_read  blkrd 4   0        0        04
blk_read  blkrd 5   0        0        08
blk_write cwr   1   0000abcd 0        0000abcd
blk_write blkwr 1   28       0        20
blk_write blkwr 5   40       0        80
blk_write req   0   0        0        0
mount     mount 1   1        1000     22
mount     size  0   0        0        1000
mount     mount 2   6        2000     c4
mount     size  0   0        0        2000
mount     mount 4   3        3000     f2
mount     mount 8   0        4000     94
mount     size  0   0        0        4000
reset     hwr   0   77       0        0
reset     iowr  0   0        0        0
reset     crd   0   0        0        77
reset     reset 0   0        0        0
reset     status 3  0        0        0
reset     req   0   0        0        0
reset     size  0   0        0        0
reset     crd   0   0        0        77

// ==== dv/disk_bridge_tb.sv ====
//==========================================================================
// Runs the operations in dv/disk_bridge_patterns.txt against the bridge.
// The host model answers block requests with random ack delays
//==========================================================================

`timescale 1ns/1ps

module disk_bridge_tb;

	localparam int MAX_PATTERNS = 128;

	logic                      clk_sys;
	logic                      areset;
	logic                      ctl_lba_sel;
	logic                      ctl_block_rd;
	logic                      ctl_block_wr;
	zpu_io_pkg::drive_num_t    ctl_drive;
	logic                      ctl_io_wr;
	logic                      ctl_data_wr;
	logic                      ctl_data_rd;
	zpu_io_pkg::ctl_word_t     ctl_wdata;
	zpu_io_pkg::status_t       ctl_status;
	zpu_io_pkg::ctl_word_t     ctl_rdata;
	sd_host_pkg::lba_t         host_lba;
	sd_host_pkg::slot_mask_t   host_rd;
	sd_host_pkg::slot_mask_t   host_wr;
	sd_host_pkg::slot_mask_t   host_ack;
	sd_host_pkg::sector_addr_t host_buf_addr;
	sd_host_pkg::byte_t        host_buf_wdata;
	logic                      host_buf_we;
	sd_host_pkg::byte_t        host_buf_rdata;
	sd_host_pkg::slot_mask_t   img_mounted;
	logic                      img_readonly;
	sd_host_pkg::image_type_t  img_type;
	sd_host_pkg::file_size_t   img_size;

	// Pattern table
	logic [8*16-1:0]           pat_name [MAX_PATTERNS];
	logic [8*8-1:0]            pat_op   [MAX_PATTERNS];
	logic [31:0]               pat_a    [MAX_PATTERNS];
	logic [31:0]               pat_b    [MAX_PATTERNS];
	logic [31:0]               pat_c    [MAX_PATTERNS];
	logic [31:0]               pat_exp  [MAX_PATTERNS];
	int                        n_patterns = 0;
	int                        setup_errors = 0;
	logic                      load_done = 1'b0;

	int unsigned               ack_hold = 0;
	int unsigned               host_delay;
	int unsigned               seed_val;
	sd_host_pkg::slot_mask_t   req_bits;

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	disk_bridge_top u_dut (
		.clk_sys (clk_sys), .areset (areset),
		.ctl_lba_sel_i (ctl_lba_sel), .ctl_block_rd_i (ctl_block_rd),
		.ctl_block_wr_i (ctl_block_wr), .ctl_drive_i (ctl_drive),
		.ctl_io_wr_i (ctl_io_wr), .ctl_data_wr_i (ctl_data_wr),
		.ctl_data_rd_i (ctl_data_rd), .ctl_wdata_i (ctl_wdata),
		.ctl_status_o (ctl_status), .ctl_rdata_o (ctl_rdata),
		.host_lba_o (host_lba), .host_rd_o (host_rd), .host_wr_o (host_wr),
		.host_ack_i (host_ack), .host_buf_addr_i (host_buf_addr),
		.host_buf_wdata_i (host_buf_wdata), .host_buf_we_i (host_buf_we),
		.host_buf_rdata_o (host_buf_rdata), .img_mounted_i (img_mounted),
		.img_readonly_i (img_readonly), .img_type_i (img_type), .img_size_i (img_size)
	);

	disk_bridge_checker u_chk (
		.clk_sys (clk_sys), .areset (areset), .ctl_status_i (ctl_status),
		.ctl_rdata_i (ctl_rdata), .host_lba_i (host_lba), .host_rd_i (host_rd),
		.host_wr_i (host_wr), .host_ack_i (host_ack), .host_buf_rdata_i (host_buf_rdata)
	);

	task automatic load_patterns();
		int               fd;
		int               cnt;
		logic [8*256-1:0] line;
		logic [8*16-1:0]  name;
		logic [8*8-1:0]   op;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      c;
		logic [31:0]      e;
		fd = $fopen("dv/disk_bridge_patterns.txt", "r");
		if (fd == 0) begin
			$display("Error: the pattern file dv/disk_bridge_patterns.txt could not be opened");
			setup_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) != 0) begin
					cnt = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, c, e);
					// Comment and blank lines do not give six fields
					if (cnt == 6 && name[7:0] != "#" && n_patterns < MAX_PATTERNS) begin
						pat_name[n_patterns] = name;
						pat_op[n_patterns]   = op;
						pat_a[n_patterns]    = a;
						pat_b[n_patterns]    = b;
						pat_c[n_patterns]    = c;
						pat_exp[n_patterns]  = e;
						n_patterns++;
					end
				end
			end
			$fclose(fd);
			if (n_patterns == 0) begin
				$display("Error: no operations were read from the pattern file");
				setup_errors++;
			end
		end
		load_done = 1'b1;
	endtask

	// Caller is at a falling edge, so the outputs are settled
	task automatic post_check(input logic [8*16-1:0] name, input logic [8*8-1:0] kind,
		input logic [31:0] mask, input logic [31:0] exp);
		u_chk.test_name = name;
		u_chk.exp_kind  = kind;
		u_chk.exp_mask  = mask;
		u_chk.exp_value = exp;
		-> u_chk.check_ev;
		#1;
	endtask

	task automatic reset_dut();
		@(posedge clk_sys);
		areset <= 1'b1;
		repeat (10) @(posedge clk_sys);
		areset <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic clear_address();
		@(posedge clk_sys);
		ctl_io_wr <= 1'b1;
		@(posedge clk_sys);
		ctl_io_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	// Strobe is seen two cycles late, held long enough for the write
	task automatic write_ctl(input logic [8*16-1:0] name, input logic sel,
		input logic [31:0] data, input logic [31:0] exp);
		@(posedge clk_sys);
		ctl_lba_sel <= sel;
		ctl_wdata   <= data;
		ctl_data_wr <= 1'b1;
		repeat (4) @(posedge clk_sys);
		ctl_data_wr <= 1'b0;
		repeat (3) @(posedge clk_sys);
		if (sel) begin
			@(negedge clk_sys);
			post_check(name, "lba", 32'hffff_ffff, exp);
			@(posedge clk_sys);
		end
		ctl_lba_sel <= 1'b0;
	endtask

	task automatic read_ctl(input logic [8*16-1:0] name, input logic [31:0] exp);
		@(posedge clk_sys);
		ctl_data_rd <= 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		post_check(name, "rdata", 32'hffff_ffff, exp);
		@(posedge clk_sys);
		ctl_data_rd <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic read_file_size(input logic [8*16-1:0] name, input logic [31:0] exp);
		@(posedge clk_sys);
		ctl_lba_sel <= 1'b1;
		@(negedge clk_sys);
		post_check(name, "rdata", 32'hffff_ffff, exp);
		@(posedge clk_sys);
		ctl_lba_sel <= 1'b0;
	endtask

	task automatic write_host(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_sys);
		host_buf_addr  <= addr[8:0];
		host_buf_wdata <= data[7:0];
		host_buf_we    <= 1'b1;
		@(posedge clk_sys);
		host_buf_we <= 1'b0;
	endtask

	task automatic read_host(input logic [8*16-1:0] name, input logic [31:0] addr,
		input logic [31:0] exp);
		@(posedge clk_sys);
		host_buf_addr <= addr[8:0];
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		post_check(name, "hbuf", 32'hff, exp);
	endtask

	// Four-phase request, io_done must stay low until ack has fallen
	task automatic block_request(input logic [8*16-1:0] name, input logic is_wr,
		input logic [31:0] drive, input logic [31:0] hold, input logic [31:0] exp);
		@(posedge clk_sys);
		ack_hold  = hold;
		ctl_drive <= drive[2:0];
		if (is_wr) begin
			ctl_block_wr <= 1'b1;
		end else begin
			ctl_block_rd <= 1'b1;
		end
		@(negedge clk_sys);
		while ((host_rd | host_wr) == '0) @(negedge clk_sys);
		post_check(name, "req", 32'hffff_ffff, exp);
		post_check(name, "status", 32'h1, 32'h0);
		@(posedge clk_sys);
		ctl_block_rd <= 1'b0;
		ctl_block_wr <= 1'b0;
		while (host_ack == '0) @(negedge clk_sys);
		while (host_ack != '0) @(negedge clk_sys);
		post_check(name, "status", 32'h1, 32'h0);
		while (ctl_status[0] == 1'b0) @(negedge clk_sys);
		post_check(name, "req", 32'hffff_ffff, 32'h0);
	endtask

	task automatic mount_image(input logic [8*16-1:0] name, input logic [31:0] slots,
		input logic [31:0] mode, input logic [31:0] size, input logic [31:0] exp);
		@(posedge clk_sys);
		img_mounted  <= slots[3:0];
		img_readonly <= mode[2];
		img_type     <= mode[1:0];
		img_size     <= size;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		post_check(name, "status", 32'hfe, exp);
		@(posedge clk_sys);
		img_mounted <= '0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic run_pattern(input int idx);
		logic [8*16-1:0] name;
		name = pat_name[idx];
		case (pat_op[idx])
			"reset":  reset_dut();
			"iowr":   clear_address();
			"cwr":    write_ctl(name, pat_a[idx][0], pat_b[idx], pat_exp[idx]);
			"crd":    read_ctl(name, pat_exp[idx]);
			"size":   read_file_size(name, pat_exp[idx]);
			"hwr":    write_host(pat_a[idx], pat_b[idx]);
			"hrd":    read_host(name, pat_a[idx], pat_exp[idx]);
			"blkrd":  block_request(name, 1'b0, pat_a[idx], pat_b[idx], pat_exp[idx]);
			"blkwr":  block_request(name, 1'b1, pat_a[idx], pat_b[idx], pat_exp[idx]);
			"mount":  mount_image(name, pat_a[idx], pat_b[idx], pat_c[idx], pat_exp[idx]);
			"status": begin
				@(negedge clk_sys);
				post_check(name, "status", pat_a[idx], pat_exp[idx]);
			end
			"req": begin
				@(negedge clk_sys);
				post_check(name, "req", 32'hffff_ffff, pat_exp[idx]);
			end
			default: begin
				$display("Error: unknown operation in pattern line %0d", idx);
				setup_errors++;
			end
		endcase
	endtask

	//==========================================================================
	// Host model, acks 3 to 8 cycles after each edge plus the hold time
	//==========================================================================

	initial begin
		seed_val = $urandom(94);
		forever begin
			@(negedge clk_sys);
			if ((host_rd | host_wr) != '0) begin
				req_bits   = host_rd | host_wr;
				host_delay = 3 + ($urandom % 6);
				repeat (host_delay) @(posedge clk_sys);
				host_ack <= req_bits;
				while ((host_rd | host_wr) != '0) @(negedge clk_sys);
				host_delay = 3 + ($urandom % 6) + ack_hold;
				repeat (host_delay) @(posedge clk_sys);
				host_ack <= '0;
			end
		end
	end

	initial begin
		wait (load_done);
		repeat (n_patterns * 200 + 20) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d clock cycles",
			n_patterns * 200 + 20);
		$display("Checks: %0d, errors: %0d", u_chk.checks, u_chk.errors + setup_errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		areset         = 1'b1;
		ctl_lba_sel    = 1'b0;
		ctl_block_rd   = 1'b0;
		ctl_block_wr   = 1'b0;
		ctl_drive      = '0;
		ctl_io_wr      = 1'b0;
		ctl_data_wr    = 1'b0;
		ctl_data_rd    = 1'b0;
		ctl_wdata      = '0;
		host_ack       = '0;
		host_buf_addr  = '0;
		host_buf_wdata = '0;
		host_buf_we    = 1'b0;
		img_mounted    = '0;
		img_readonly   = 1'b0;
		img_type       = '0;
		img_size       = '0;
		load_patterns();
		repeat (10) @(posedge clk_sys);
		areset <= 1'b0;
		@(posedge clk_sys);
		for (int i = 0; i < n_patterns; i++) begin
			run_pattern(i);
		end
		repeat (5) @(posedge clk_sys);
		$display("Checks: %0d, errors: %0d", u_chk.checks, u_chk.errors + setup_errors);
		if (u_chk.errors == 0 && setup_errors == 0 && u_chk.checks > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/disk_bridge_checker.sv ====
//==========================================================================
// Compares DUT outputs on each check event raised by the testbench and
// watches the block request handshake on every falling clock edge
//==========================================================================

`timescale 1ns/1ps

module disk_bridge_checker (
	input  logic                    clk_sys,
	input  logic                    areset,
	input  zpu_io_pkg::status_t     ctl_status_i,
	input  zpu_io_pkg::ctl_word_t   ctl_rdata_i,
	input  sd_host_pkg::lba_t       host_lba_i,
	input  sd_host_pkg::slot_mask_t host_rd_i,
	input  sd_host_pkg::slot_mask_t host_wr_i,
	input  sd_host_pkg::slot_mask_t host_ack_i,
	input  sd_host_pkg::byte_t      host_buf_rdata_i
);

	// Set by the testbench before each trigger
	event                    check_ev;
	logic [8*16-1:0]         test_name;
	logic [8*8-1:0]          exp_kind;
	logic [31:0]             exp_mask;
	logic [31:0]             exp_value;

	int                      checks = 0;
	int                      errors = 0;
	logic [31:0]             actual;
	sd_host_pkg::slot_mask_t req_q = '0;

	always @(check_ev) begin
		case (exp_kind)
			"lba":    actual = host_lba_i;
			"rdata":  actual = ctl_rdata_i;
			"hbuf":   actual = host_buf_rdata_i;
			"req":    actual = {host_wr_i, host_rd_i};
			"status": actual = ctl_status_i;
			default:  actual = 'x;
		endcase
		checks++;
		if ((actual & exp_mask) !== (exp_value & exp_mask)) begin
			errors++;
			$display("Mismatch in %0s (%0s): expected %h, actual %h", test_name, exp_kind,
				exp_value & exp_mask, actual & exp_mask);
		end
	end

	//==========================================================================
	// Handshake monitor
	//==========================================================================

	always @(negedge clk_sys) begin
		if (!areset) begin
			// io_done only after the host has released ack
			if (ctl_status_i[0] && ((host_rd_i | host_wr_i | host_ack_i) != '0)) begin
				errors++;
				$display("Error: io_done is set while a block request or its ack is active");
			end
			if ((req_q == '0) && ((host_rd_i | host_wr_i) != '0) && (host_ack_i != '0)) begin
				errors++;
				$display("Error: a block request was raised while the host ack was high");
			end
		end
		req_q = host_rd_i | host_wr_i;
	end

endmodule

// ==== verilog/disk_bridge_top.sv ====
//==========================================================================
// Disk-image bridge between the emulator controller and the SD host.
// Host buffer access and controller access must not overlap in time
//==========================================================================

`timescale 1ns/1ps

module disk_bridge_top (
	input  logic                     clk_sys,
	input  logic                     areset,

	// Controller registers
	input  logic                     ctl_lba_sel_i,
	input  logic                     ctl_block_rd_i,
	input  logic                     ctl_block_wr_i,
	input  zpu_io_pkg::drive_num_t   ctl_drive_i,
	input  logic                     ctl_io_wr_i,
	input  logic                     ctl_data_wr_i,
	input  logic                     ctl_data_rd_i,
	input  zpu_io_pkg::ctl_word_t    ctl_wdata_i,
	output zpu_io_pkg::status_t      ctl_status_o,
	output zpu_io_pkg::ctl_word_t    ctl_rdata_o,

	// Host block requests
	output sd_host_pkg::lba_t        host_lba_o,
	output sd_host_pkg::slot_mask_t  host_rd_o,
	output sd_host_pkg::slot_mask_t  host_wr_o,
	input  sd_host_pkg::slot_mask_t  host_ack_i,

	// Host buffer port
	input  sd_host_pkg::sector_addr_t host_buf_addr_i,
	input  sd_host_pkg::byte_t       host_buf_wdata_i,
	input  logic                     host_buf_we_i,
	output sd_host_pkg::byte_t       host_buf_rdata_o,

	// Mount events
	input  sd_host_pkg::slot_mask_t  img_mounted_i,
	input  logic                     img_readonly_i,
	input  sd_host_pkg::image_type_t img_type_i,
	input  sd_host_pkg::file_size_t  img_size_i
);

	logic                     io_done;
	zpu_io_pkg::file_no_t     file_no;
	sd_host_pkg::image_type_t img_type;
	logic                     readonly;
	logic                     mounted_tgl;
	sd_host_pkg::file_size_t  file_size;

	sector_port_if u_port_if ();

	sector_buffer u_buffer (
		.clk_sys      (clk_sys),
		.host_addr_i  (host_buf_addr_i),
		.host_wdata_i (host_buf_wdata_i),
		.host_we_i    (host_buf_we_i),
		.host_rdata_o (host_buf_rdata_o),
		.port         (u_port_if.mem)
	);

	disk_request_ctrl u_req_ctrl (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.ctl_lba_sel_i  (ctl_lba_sel_i),
		.ctl_block_rd_i (ctl_block_rd_i),
		.ctl_block_wr_i (ctl_block_wr_i),
		.ctl_drive_i    (ctl_drive_i),
		.ctl_io_wr_i    (ctl_io_wr_i),
		.ctl_data_wr_i  (ctl_data_wr_i),
		.ctl_data_rd_i  (ctl_data_rd_i),
		.ctl_wdata_i    (ctl_wdata_i),
		.host_ack_i     (host_ack_i),
		.host_lba_o     (host_lba_o),
		.host_rd_o      (host_rd_o),
		.host_wr_o      (host_wr_o),
		.io_done_o      (io_done),
		.port           (u_port_if.ctrl)
	);

	mount_tracker u_mount (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_type_i     (img_type_i),
		.img_size_i     (img_size_i),
		.file_no_o      (file_no),
		.img_type_o     (img_type),
		.readonly_o     (readonly),
		.mounted_tgl_o  (mounted_tgl),
		.file_size_o    (file_size)
	);

	// Status byte as the firmware expects it
	assign ctl_status_o = {readonly, img_type, file_no, mounted_tgl, io_done};

	// LBA select doubles as the file-size read select
	assign ctl_rdata_o = ctl_lba_sel_i ? zpu_io_pkg::ctl_word_t'(file_size)
	                                   : zpu_io_pkg::ctl_word_t'(u_port_if.buf_rdata);

endmodule

// ==== verilog/mount_tracker.sv ====
//==========================================================================
// Acts on the rising edge of the OR of the mount bits only, so a second
// slot mounted while another bit is still high is not seen
//==========================================================================

`timescale 1ns/1ps
`include "disk_defs.svh"

module mount_tracker (
	input  logic                     clk_sys,
	input  logic                     areset,

	input  sd_host_pkg::slot_mask_t  img_mounted_i,
	input  logic                     img_readonly_i,
	input  sd_host_pkg::image_type_t img_type_i,
	input  sd_host_pkg::file_size_t  img_size_i,

	output zpu_io_pkg::file_no_t     file_no_o,
	output sd_host_pkg::image_type_t img_type_o,
	output logic                     readonly_o,
	output logic                     mounted_tgl_o,
	output sd_host_pkg::file_size_t  file_size_o
);

	logic                             mounted_q;
	logic [$clog2(`DISK_SLOTS)-1:0]   slot_idx;

	// Highest set slot wins
	always_comb begin
		slot_idx = '0;
		for (int i = 0; i < `DISK_SLOTS; i++) begin
			if (img_mounted_i[i]) begin
				slot_idx = i[$clog2(`DISK_SLOTS)-1:0];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted_q     <= 1'b0;
			file_no_o     <= '0;
			img_type_o    <= '0;
			readonly_o    <= 1'b0;
			mounted_tgl_o <= 1'b0;
			file_size_o   <= '0;
		end else begin
			mounted_q <= |img_mounted_i;
			if (!mounted_q && |img_mounted_i) begin
				// Slots 0..3 map to files 0, 1, 4, 5
				file_no_o     <= {slot_idx[1], 1'b0, slot_idx[0]};
				img_type_o    <= img_type_i;
				// Slots 2 and 3 are always read-only
				readonly_o    <= img_readonly_i | img_mounted_i[2] | img_mounted_i[3];
				mounted_tgl_o <= ~mounted_tgl_o;
				file_size_o   <= img_size_i;
			end
		end
	end

endmodule

// ==== verilog/disk_request_ctrl.sv ====
//==========================================================================
// Controller strobes are levels and only their edges act. A new block
// request is ignored until the previous one has completed
//==========================================================================

`timescale 1ns/1ps
`include "disk_defs.svh"

module disk_request_ctrl (
	input  logic                     clk_sys,
	input  logic                     areset,

	// Controller register side
	input  logic                     ctl_lba_sel_i,
	input  logic                     ctl_block_rd_i,
	input  logic                     ctl_block_wr_i,
	input  zpu_io_pkg::drive_num_t   ctl_drive_i,
	input  logic                     ctl_io_wr_i,
	input  logic                     ctl_data_wr_i,
	input  logic                     ctl_data_rd_i,
	input  zpu_io_pkg::ctl_word_t    ctl_wdata_i,

	// Host request side
	input  sd_host_pkg::slot_mask_t  host_ack_i,
	output sd_host_pkg::lba_t        host_lba_o,
	output sd_host_pkg::slot_mask_t  host_rd_o,
	output sd_host_pkg::slot_mask_t  host_wr_o,

	output logic                     io_done_o,

	sector_port_if.ctrl              port
);

	localparam int SLOT_W = $clog2(`DISK_SLOTS);

	logic [`REQ_SYNC_STAGES-1:0] wr_sync;
	logic                        wr_edge;
	logic                        rd_q;
	logic                        blk_rd_q;
	logic                        blk_wr_q;
	logic [SLOT_W-1:0]           slot_sel;
	sd_host_pkg::slot_mask_t     req_mask;
	zpu_io_pkg::req_state_t      state;

	assign wr_edge  = wr_sync[`REQ_SYNC_STAGES-2] & ~wr_sync[`REQ_SYNC_STAGES-1];
	assign slot_sel = {ctl_drive_i[2], ctl_drive_i[0]};
	assign req_mask = sd_host_pkg::slot_mask_t'(1) << slot_sel;

	//==========================================================================
	// Buffer address counter and LBA register
	//==========================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_sync       <= '0;
			rd_q          <= 1'b0;
			port.buf_we   <= 1'b0;
			port.buf_addr <= '0;
			host_lba_o    <= '0;
		end else begin
			wr_sync     <= {wr_sync[`REQ_SYNC_STAGES-2:0], ctl_data_wr_i};
			rd_q        <= ctl_data_rd_i;
			port.buf_we <= 1'b0;

			if (wr_edge) begin
				if (ctl_lba_sel_i) begin
					host_lba_o <= ctl_wdata_i;
				end else begin
					port.buf_we <= 1'b1;
				end
			end

			// Post-increment after a byte write or at the end of a read
			if (port.buf_we || (rd_q && !ctl_data_rd_i)) begin
				port.buf_addr <= port.buf_addr + sd_host_pkg::sector_addr_t'(1);
			end

			if (ctl_io_wr_i) begin
				port.buf_addr <= '0;
			end
		end
	end

	// Write byte captured with the strobe edge
	always_ff @(posedge clk_sys) begin
		if (wr_edge && !ctl_lba_sel_i) begin
			port.buf_wdata <= ctl_wdata_i[7:0];
		end
	end

	//==========================================================================
	// Block request FSM
	//==========================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			state     <= zpu_io_pkg::REQ_IDLE;
			blk_rd_q  <= 1'b0;
			blk_wr_q  <= 1'b0;
			host_rd_o <= '0;
			host_wr_o <= '0;
			io_done_o <= 1'b0;
		end else begin
			blk_rd_q <= ctl_block_rd_i;
			blk_wr_q <= ctl_block_wr_i;

			case (state)
				zpu_io_pkg::REQ_IDLE: begin
					if (ctl_block_rd_i && !blk_rd_q) begin
						host_rd_o <= req_mask;
						io_done_o <= 1'b0;
						state     <= zpu_io_pkg::REQ_ASSERT;
					end else if (ctl_block_wr_i && !blk_wr_q) begin
						host_wr_o <= req_mask;
						io_done_o <= 1'b0;
						state     <= zpu_io_pkg::REQ_ASSERT;
					end
				end
				// Drop the request once the host has taken it
				zpu_io_pkg::REQ_ASSERT: begin
					if (|host_ack_i) begin
						host_rd_o <= '0;
						host_wr_o <= '0;
						state     <= zpu_io_pkg::REQ_WAIT_RELEASE;
					end
				end
				// Host may hold ack as long as the transfer runs
				zpu_io_pkg::REQ_WAIT_RELEASE: begin
					if (host_ack_i == '0) begin
						io_done_o <= 1'b1;
						state     <= zpu_io_pkg::REQ_IDLE;
					end
				end
				default: state <= zpu_io_pkg::REQ_IDLE;
			endcase
		end
	end

	a_one_request : assert property (
		@(posedge clk_sys) disable iff (areset)
		$onehot0({host_rd_o, host_wr_o})
	) else $error("more than one block request bit high");

	a_req_after_release : assert property (
		@(posedge clk_sys) disable iff (areset)
		$rose(|{host_rd_o, host_wr_o}) |-> $past(host_ack_i == '0)
	) else $error("block request raised while host ack was high");

	a_done_after_release : assert property (
		@(posedge clk_sys) disable iff (areset)
		$rose(io_done_o) |-> ($past(host_ack_i == '0) && (host_ack_i == '0))
	) else $error("io_done raised while host ack was high");

endmodule

// ==== verilog/sector_buffer.sv ====
//==========================================================================
// True dual-port sector RAM, no reset, contents undefined after power-up.
// Read-during-write on one port returns the old byte
//==========================================================================

`timescale 1ns/1ps
`include "disk_defs.svh"

module sector_buffer (
	input  logic                      clk_sys,

	// Host side, used by the SD transfer engine
	input  sd_host_pkg::sector_addr_t host_addr_i,
	input  sd_host_pkg::byte_t        host_wdata_i,
	input  logic                      host_we_i,
	output sd_host_pkg::byte_t        host_rdata_o,

	// Controller side
	sector_port_if.mem                port
);

	sd_host_pkg::byte_t mem [`SECTOR_BYTES];

	//==========================================================================
	// Host port
	//==========================================================================

	always @(posedge clk_sys) begin
		if (host_we_i) begin
			mem[host_addr_i] <= host_wdata_i;
		end
		host_rdata_o <= mem[host_addr_i];
	end

	//==========================================================================
	// Controller port
	//==========================================================================

	always @(posedge clk_sys) begin
		if (port.buf_we) begin
			mem[port.buf_addr] <= port.buf_wdata;
		end
		port.buf_rdata <= mem[port.buf_addr];
	end

	// Host and controller never own the buffer at the same time, so
	// a write collision means the firmware ran during a transfer
	a_no_write_collision : assert property (
		@(posedge clk_sys)
		!(host_we_i && port.buf_we && (host_addr_i == port.buf_addr))
	) else $error("sector buffer written from both ports at one address");

endmodule

// ==== verilog/sector_port_if.sv ====
//==========================================================================
// Controller port of the sector buffer. Read data follows the address by
// one clock; a write takes effect on the clock where buf_we is high
//==========================================================================

`timescale 1ns/1ps

interface sector_port_if;

	// Driven by the request controller
	sd_host_pkg::sector_addr_t buf_addr;
	logic                      buf_we;
	sd_host_pkg::byte_t        buf_wdata;

	// Driven by the RAM
	sd_host_pkg::byte_t        buf_rdata;

	modport ctrl (
		output buf_addr,
		output buf_we,
		output buf_wdata
	);

	modport mem (
		input  buf_addr,
		input  buf_we,
		input  buf_wdata,
		output buf_rdata
	);

endinterface

// ==== verilog/zpu_io_pkg.sv ====
//==========================================================================
// Types of the controller register side. The status byte layout is
// fixed by the controller firmware and must not be reordered
//==========================================================================

package zpu_io_pkg;

	// Data word written and read by the controller
	typedef logic [31:0] ctl_word_t;

	// Drive number, bits 2 and 0 select the slot
	typedef logic [2:0] drive_num_t;

	// File number reported in the status byte
	typedef logic [2:0] file_no_t;

	// Status byte
	// [0] io_done, [1] mount toggle, [4:2] file number,
	// [6:5] image type, [7] read-only
	typedef logic [7:0] status_t;

	// Four-phase block request towards the host
	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_ASSERT,
		REQ_WAIT_RELEASE
	} req_state_t;

endpackage

// ==== verilog/sd_host_pkg.sv ====
//==========================================================================
// Types of the host/SD side of the bridge. Slot masks are one bit per
// drive slot. Only the low 32 bits of the image size are carried
//==========================================================================

`include "disk_defs.svh"

package sd_host_pkg;

	// One data byte on either buffer port
	typedef logic [7:0] byte_t;

	// Byte address inside the sector buffer
	typedef logic [`SECTOR_AW-1:0] sector_addr_t;

	// Logical block address sent with a block request
	typedef logic [31:0] lba_t;

	// Request, acknowledge and mount vectors
	typedef logic [`DISK_SLOTS-1:0] slot_mask_t;

	// Image class reported by the host when a file is mounted
	typedef logic [1:0] image_type_t;

	// Size of the mounted image in bytes
	typedef logic [31:0] file_size_t;

endpackage

// ==== verilog/disk_defs.svh ====
//==========================================================================
// Sizing of the disk-image bridge. SECTOR_BYTES must equal 2**SECTOR_AW
// and REQ_SYNC_STAGES must be at least 2 for the edge detector to work
//==========================================================================

`ifndef DISK_DEFS_SVH
`define DISK_DEFS_SVH

// Number of drive slots served by the host, one request bit each
`define DISK_SLOTS 4

// Sector buffer depth in bytes
`define SECTOR_BYTES 512

// Buffer address width, log2 of SECTOR_BYTES
`define SECTOR_AW 9

// Delay stages on the controller data-write strobe
// The edge is taken between the last two stages
`define REQ_SYNC_STAGES 2

`endif
